// File: hw/stream_pkg.sv
/*
 * Shared types for the host stream core: application and length types,
 * APB request and response structs, register map and descriptor payloads
 */
`default_nettype none

package stream_pkg;

	// Register map packs the application into two address bits
	localparam int N_APPS = 4;

	typedef logic [1:0]  app_t;
	typedef logic [14:0] beat_idx_t;
	typedef logic [5:0]  burst_len_t;
	typedef logic [14:0] req_len_t;

	// Register within an application, paddr[3:2]
	typedef enum logic [1:0] {
		REG_SEND_REQ  = 2'd0,
		REG_RECV_REQ  = 2'd1,
		REG_RECV_CRED = 2'd2,
		REG_SEND_DONE = 2'd3
	} reg_sel_e;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic [31:0] prdata;
		logic        pslverr;
	} apb_resp_t;

	typedef struct packed {
		app_t       app;
		beat_idx_t  idx;
		burst_len_t len;
		logic       last;
	} seg_desc_t;

	typedef struct packed {
		app_t       app;
		burst_len_t len;
	} recv_desc_t;

	typedef enum logic {
		DESC_SEND = 1'b0,
		DESC_RECV = 1'b1
	} desc_kind_e;

	// idx and last are zero for receive grants
	typedef struct packed {
		desc_kind_e kind;
		app_t       app;
		beat_idx_t  idx;
		burst_len_t len;
		logic       last;
	} out_desc_t;

endpackage

`default_nettype wire

// File: hw/rr_arbiter.sv
/* Round-robin arbiter over the application request lines */
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          ready,
	input  logic [stream_pkg::N_APPS-1:0] reqs,
	output stream_pkg::app_t              sel
);

	logic [stream_pkg::N_APPS-1:0] granted;
	logic [stream_pkg::N_APPS-1:0] granted_nxt;
	logic                          found;

	// Lowest requester not yet served this round
	always_comb begin
		sel = '0;
		granted_nxt = granted;
		found = 1'b0;
		for (int i = 0; i < stream_pkg::N_APPS; i++) begin
			if (reqs[i] && !granted[i] && !found) begin
				sel = stream_pkg::app_t'(i);
				granted_nxt = granted;
				granted_nxt[i] = 1'b1;
				found = 1'b1;
			end
		end
		// Round over, lowest requester opens the next one
		for (int i = 0; i < stream_pkg::N_APPS; i++) begin
			if (reqs[i] && !found) begin
				sel = stream_pkg::app_t'(i);
				granted_nxt = '0;
				granted_nxt[i] = 1'b1;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			granted <= '0;
		end else if (ready) begin
			granted <= granted_nxt;
		end
	end

endmodule

`default_nettype wire

// File: hw/apb_regs.sv
/*
 * APB slave for the per-application registers: posts send and receive
 * requests and credit grants, keeps the send-completion counters
 */
`timescale 1ns/10ps
`default_nettype none

module apb_regs #(
	parameter int CRED_W = 16
) (
	input  logic                                       clk,
	input  logic                                       rst,
	input  stream_pkg::apb_req_t                       apb_req,
	output stream_pkg::apb_resp_t                      apb_resp,
	output logic                                       post_send_valid,
	output stream_pkg::app_t                           post_send_app,
	output stream_pkg::req_len_t                       post_send_len,
	output logic                                       post_recv_valid,
	output stream_pkg::app_t                           post_recv_app,
	output stream_pkg::burst_len_t                     post_recv_len,
	output logic                                       cred_add_valid,
	output stream_pkg::app_t                           cred_add_app,
	output logic [CRED_W-1:0]                          cred_add_amount,
	input  logic [stream_pkg::N_APPS-1:0]              send_busy,
	input  logic [stream_pkg::N_APPS-1:0]              recv_busy,
	input  logic [stream_pkg::N_APPS-1:0][CRED_W-1:0]  credits,
	input  logic                                       send_done_valid,
	input  stream_pkg::app_t                           send_done_app
);

	stream_pkg::reg_sel_e reg_sel;
	stream_pkg::app_t     app;
	stream_pkg::app_t     post_app_q;
	logic                 access;
	logic                 wr;
	logic                 rd;
	logic                 send_blocked;
	logic                 recv_blocked;
	logic                 send_post;
	logic                 recv_post;
	logic [15:0]          done_cnt [stream_pkg::N_APPS];

	assign reg_sel = stream_pkg::reg_sel_e'(apb_req.paddr[3:2]);
	assign app = apb_req.paddr[5:4];
	assign access = apb_req.psel && apb_req.penable;
	assign wr = access && apb_req.pwrite;
	assign rd = access && !apb_req.pwrite;

	// Busy also covers a post still on its way to the path
	assign send_blocked = send_busy[app] || (post_send_valid && post_send_app == app);
	assign recv_blocked = recv_busy[app] || (post_recv_valid && post_recv_app == app);

	assign send_post = wr && reg_sel == stream_pkg::REG_SEND_REQ && !send_blocked;
	assign recv_post = wr && reg_sel == stream_pkg::REG_RECV_REQ && !recv_blocked;

	always_comb begin
		apb_resp.pready = 1'b1;
		apb_resp.pslverr = wr && ((reg_sel == stream_pkg::REG_SEND_REQ && send_blocked) ||
			(reg_sel == stream_pkg::REG_RECV_REQ && recv_blocked));
		case (reg_sel)
			stream_pkg::REG_RECV_CRED: apb_resp.prdata = 32'(credits[app]);
			stream_pkg::REG_SEND_DONE: apb_resp.prdata = 32'(done_cnt[app]);
			default:                   apb_resp.prdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			post_send_valid <= 1'b0;
			post_recv_valid <= 1'b0;
			cred_add_valid <= 1'b0;
		end else begin
			post_send_valid <= send_post;
			post_recv_valid <= recv_post;
			cred_add_valid <= wr && reg_sel == stream_pkg::REG_RECV_CRED;
		end
	end

	// Write payload, qualified by the valids above
	always_ff @(posedge clk) begin
		if (wr) begin
			post_app_q <= app;
			post_send_len <= apb_req.pwdata[14:0];
			post_recv_len <= apb_req.pwdata[5:0];
			cred_add_amount <= apb_req.pwdata[CRED_W-1:0];
		end
	end

	assign post_send_app = post_app_q;
	assign post_recv_app = post_app_q;
	assign cred_add_app = post_app_q;

	// Read clears; a completion in the same cycle leaves a count of one
	always_ff @(posedge clk) begin
		for (int i = 0; i < stream_pkg::N_APPS; i++) begin
			if (rst) begin
				done_cnt[i] <= '0;
			end else if (rd && reg_sel == stream_pkg::REG_SEND_DONE &&
				app == stream_pkg::app_t'(i)) begin
				done_cnt[i] <= 16'(send_done_valid && send_done_app == stream_pkg::app_t'(i));
			end else if (send_done_valid && send_done_app == stream_pkg::app_t'(i)) begin
				done_cnt[i] <= done_cnt[i] + 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/send_segmenter.sv
/* Per-application send requests, cut into page-bounded bursts */
`timescale 1ns/10ps
`default_nettype none

module send_segmenter (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          post_valid,
	input  stream_pkg::app_t              post_app,
	input  stream_pkg::req_len_t          post_len,
	output logic [stream_pkg::N_APPS-1:0] busy,
	output logic                          seg_valid,
	output stream_pkg::seg_desc_t         seg_desc,
	input  logic                          seg_ready,
	output logic                          done_valid,
	output stream_pkg::app_t              done_app
);

	logic [stream_pkg::N_APPS-1:0] pending;
	logic [stream_pkg::N_APPS-1:0] arb_reqs;
	logic [stream_pkg::N_APPS-1:0] stall_mask;
	stream_pkg::req_len_t          req_len [stream_pkg::N_APPS];
	stream_pkg::req_len_t          beats_done [stream_pkg::N_APPS];
	stream_pkg::beat_idx_t         idx [stream_pkg::N_APPS];
	stream_pkg::app_t              arb_sel;
	stream_pkg::app_t              stall_app;
	stream_pkg::req_len_t          left;
	stream_pkg::burst_len_t        room;
	logic                          stall;
	logic                          xfer;

	// A stalled burst keeps its application until it transfers
	always_comb begin
		stall_mask = '0;
		stall_mask[stall_app] = 1'b1;
		arb_reqs = stall ? stall_mask : pending;
	end

	rr_arbiter arb0 (
		.clk   (clk),
		.rst   (rst),
		.ready (xfer),
		.reqs  (arb_reqs),
		.sel   (arb_sel)
	);

	always_comb begin
		left = req_len[arb_sel] - beats_done[arb_sel];
		room = 6'd63 - idx[arb_sel][5:0];
		seg_desc.app = arb_sel;
		seg_desc.idx = idx[arb_sel];
		seg_desc.last = left <= stream_pkg::req_len_t'(room);
		seg_desc.len = seg_desc.last ? left[5:0] : room;
	end

	assign busy = pending;
	assign seg_valid = |arb_reqs;
	assign xfer = seg_valid && seg_ready;
	assign done_valid = xfer && seg_desc.last;
	assign done_app = arb_sel;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
			stall <= 1'b0;
			for (int i = 0; i < stream_pkg::N_APPS; i++) begin
				idx[i] <= '0;
				beats_done[i] <= '0;
			end
		end else begin
			stall <= seg_valid && !seg_ready;
			if (post_valid) begin
				pending[post_app] <= 1'b1;
			end
			if (xfer) begin
				idx[arb_sel] <= idx[arb_sel] + stream_pkg::beat_idx_t'(seg_desc.len) + 15'd1;
				if (seg_desc.last) begin
					pending[arb_sel] <= 1'b0;
					beats_done[arb_sel] <= '0;
				end else begin
					beats_done[arb_sel] <= beats_done[arb_sel] +
						stream_pkg::req_len_t'(seg_desc.len) + 15'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		stall_app <= arb_sel;
		if (post_valid) begin
			req_len[post_app] <= post_len;
		end
	end

	// Burst stays inside its 64-beat page
	assert property (@(posedge clk) disable iff (rst)
		seg_valid |-> 7'(seg_desc.idx[5:0]) + 7'(seg_desc.len) <= 7'd63);

	assert property (@(posedge clk) disable iff (rst)
		seg_valid && !seg_ready |=> seg_valid && $stable(seg_desc));

endmodule

`default_nettype wire

// File: hw/recv_gate.sv
/* Per-application receive requests held until the host credit suffices */
`timescale 1ns/10ps
`default_nettype none

module recv_gate #(
	parameter int CRED_W = 16
) (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic                                      post_valid,
	input  stream_pkg::app_t                          post_app,
	input  stream_pkg::burst_len_t                    post_len,
	input  logic                                      cred_valid,
	input  stream_pkg::app_t                          cred_app,
	input  logic [CRED_W-1:0]                         cred_amount,
	output logic [stream_pkg::N_APPS-1:0]             busy,
	output logic [stream_pkg::N_APPS-1:0][CRED_W-1:0] credits,
	output logic                                      rcv_valid,
	output stream_pkg::recv_desc_t                    rcv_desc,
	input  logic                                      rcv_ready
);

	logic [stream_pkg::N_APPS-1:0] pending;
	logic [stream_pkg::N_APPS-1:0] admissible;
	logic [stream_pkg::N_APPS-1:0] arb_reqs;
	logic [stream_pkg::N_APPS-1:0] stall_mask;
	stream_pkg::burst_len_t        plen [stream_pkg::N_APPS];
	stream_pkg::app_t              arb_sel;
	stream_pkg::app_t              stall_app;
	logic                          stall;
	logic                          xfer;

	// Credits only fall on transfer, so an admitted request stays admitted
	always_comb begin
		for (int i = 0; i < stream_pkg::N_APPS; i++) begin
			admissible[i] = pending[i] && credits[i] > CRED_W'(plen[i]);
		end
		stall_mask = '0;
		stall_mask[stall_app] = 1'b1;
		arb_reqs = stall ? (admissible & stall_mask) : admissible;
	end

	rr_arbiter arb0 (
		.clk   (clk),
		.rst   (rst),
		.ready (xfer),
		.reqs  (arb_reqs),
		.sel   (arb_sel)
	);

	assign busy = pending;
	assign rcv_valid = |arb_reqs;
	assign rcv_desc.app = arb_sel;
	assign rcv_desc.len = plen[arb_sel];
	assign xfer = rcv_valid && rcv_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
			stall <= 1'b0;
			credits <= '0;
		end else begin
			stall <= rcv_valid && !rcv_ready;
			if (post_valid) begin
				pending[post_app] <= 1'b1;
			end
			if (xfer) begin
				pending[arb_sel] <= 1'b0;
			end
			for (int i = 0; i < stream_pkg::N_APPS; i++) begin
				credits[i] <= credits[i]
					+ ((cred_valid && cred_app == stream_pkg::app_t'(i)) ? cred_amount : '0)
					- ((xfer && arb_sel == stream_pkg::app_t'(i)) ?
						CRED_W'(plen[i]) + CRED_W'(1) : '0);
			end
		end
	end

	always_ff @(posedge clk) begin
		stall_app <= arb_sel;
		if (post_valid) begin
			plen[post_app] <= post_len;
		end
	end

	// A debit never wraps the counter below zero
	assert property (@(posedge clk) disable iff (rst)
		xfer && !(cred_valid && cred_app == arb_sel) |=>
			credits[$past(arb_sel)] < $past(credits[arb_sel]));

endmodule

`default_nettype wire

// File: hw/desc_merger.sv
/* Output register stage alternating between send and receive descriptors */
`timescale 1ns/10ps
`default_nettype none

module desc_merger (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   seg_valid,
	input  stream_pkg::seg_desc_t  seg_desc,
	output logic                   seg_ready,
	input  logic                   rcv_valid,
	input  stream_pkg::recv_desc_t rcv_desc,
	output logic                   rcv_ready,
	output logic                   out_valid,
	output stream_pkg::out_desc_t  out_desc,
	input  logic                   out_ready
);

	logic take;
	logic pick_recv;
	logic last_recv;

	// Register free or draining this cycle
	assign take = !out_valid || out_ready;
	assign pick_recv = rcv_valid && (!seg_valid || !last_recv);
	assign seg_ready = take && !pick_recv;
	assign rcv_ready = take && pick_recv;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			last_recv <= 1'b0;
		end else if (take) begin
			out_valid <= seg_valid || rcv_valid;
			if (seg_valid || rcv_valid) begin
				last_recv <= pick_recv;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			if (pick_recv) begin
				out_desc.kind <= stream_pkg::DESC_RECV;
				out_desc.app <= rcv_desc.app;
				out_desc.idx <= '0;
				out_desc.len <= rcv_desc.len;
				out_desc.last <= 1'b0;
			end else begin
				out_desc.kind <= stream_pkg::DESC_SEND;
				out_desc.app <= seg_desc.app;
				out_desc.idx <= seg_desc.idx;
				out_desc.len <= seg_desc.len;
				out_desc.last <= seg_desc.last;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_desc));

endmodule

`default_nettype wire

// File: hw/host_stream_top.sv
/* Host stream core top: register slave, send and receive paths, merger */
`timescale 1ns/10ps
`default_nettype none

module host_stream_top #(
	parameter int CRED_W = 16
) (
	input  logic                  clk,
	input  logic                  rst,
	input  stream_pkg::apb_req_t  apb_req,
	output stream_pkg::apb_resp_t apb_resp,
	output logic                  out_valid,
	output stream_pkg::out_desc_t out_desc,
	input  logic                  out_ready
);

	logic                                      post_send_valid;
	stream_pkg::app_t                          post_send_app;
	stream_pkg::req_len_t                      post_send_len;
	logic                                      post_recv_valid;
	stream_pkg::app_t                          post_recv_app;
	stream_pkg::burst_len_t                    post_recv_len;
	logic                                      cred_add_valid;
	stream_pkg::app_t                          cred_add_app;
	logic [CRED_W-1:0]                         cred_add_amount;
	logic [stream_pkg::N_APPS-1:0]             send_busy;
	logic [stream_pkg::N_APPS-1:0]             recv_busy;
	logic [stream_pkg::N_APPS-1:0][CRED_W-1:0] credits;
	logic                                      send_done_valid;
	stream_pkg::app_t                          send_done_app;
	logic                                      seg_valid;
	stream_pkg::seg_desc_t                     seg_desc;
	logic                                      seg_ready;
	logic                                      rcv_valid;
	stream_pkg::recv_desc_t                    rcv_desc;
	logic                                      rcv_ready;

	apb_regs #(
		.CRED_W (CRED_W)
	) regs0 (
		.clk             (clk),
		.rst             (rst),
		.apb_req         (apb_req),
		.apb_resp        (apb_resp),
		.post_send_valid (post_send_valid),
		.post_send_app   (post_send_app),
		.post_send_len   (post_send_len),
		.post_recv_valid (post_recv_valid),
		.post_recv_app   (post_recv_app),
		.post_recv_len   (post_recv_len),
		.cred_add_valid  (cred_add_valid),
		.cred_add_app    (cred_add_app),
		.cred_add_amount (cred_add_amount),
		.send_busy       (send_busy),
		.recv_busy       (recv_busy),
		.credits         (credits),
		.send_done_valid (send_done_valid),
		.send_done_app   (send_done_app)
	);

	send_segmenter seg0 (
		.clk        (clk),
		.rst        (rst),
		.post_valid (post_send_valid),
		.post_app   (post_send_app),
		.post_len   (post_send_len),
		.busy       (send_busy),
		.seg_valid  (seg_valid),
		.seg_desc   (seg_desc),
		.seg_ready  (seg_ready),
		.done_valid (send_done_valid),
		.done_app   (send_done_app)
	);

	recv_gate #(
		.CRED_W (CRED_W)
	) gate0 (
		.clk         (clk),
		.rst         (rst),
		.post_valid  (post_recv_valid),
		.post_app    (post_recv_app),
		.post_len    (post_recv_len),
		.cred_valid  (cred_add_valid),
		.cred_app    (cred_add_app),
		.cred_amount (cred_add_amount),
		.busy        (recv_busy),
		.credits     (credits),
		.rcv_valid   (rcv_valid),
		.rcv_desc    (rcv_desc),
		.rcv_ready   (rcv_ready)
	);

	desc_merger merge0 (
		.clk       (clk),
		.rst       (rst),
		.seg_valid (seg_valid),
		.seg_desc  (seg_desc),
		.seg_ready (seg_ready),
		.rcv_valid (rcv_valid),
		.rcv_desc  (rcv_desc),
		.rcv_ready (rcv_ready),
		.out_valid (out_valid),
		.out_desc  (out_desc),
		.out_ready (out_ready)
	);

endmodule

`default_nettype wire

// File: verif/tb_host_stream.sv
/*
 * Testbench for the host stream core: APB driver, LFSR stimulus,
 * reference model of bursts and credits, descriptor checker, timeout
 */
`timescale 1ns/10ps
`default_nettype none

module tb_host_stream;

	localparam int CRED_W = 16;

	logic                  clk;
	logic                  rst;
	stream_pkg::apb_req_t  apb_req;
	stream_pkg::apb_resp_t apb_resp;
	logic                  out_valid;
	stream_pkg::out_desc_t out_desc;
	logic                  out_ready;

	stream_pkg::out_desc_t exp_q [$];
	stream_pkg::beat_idx_t model_idx [stream_pkg::N_APPS];
	logic [CRED_W-1:0]     model_cred [stream_pkg::N_APPS];
	int                    model_done [stream_pkg::N_APPS];
	logic                  held [stream_pkg::N_APPS];
	stream_pkg::burst_len_t held_len [stream_pkg::N_APPS];
	logic [31:0]           stim_state;
	logic [31:0]           ready_state;
	logic                  ready_random;
	logic [31:0]           rdata;
	logic                  err;
	int                    errors;
	int                    checks;
	int                    beat_total;
	int                    cycles;

	host_stream_top #(
		.CRED_W (CRED_W)
	) dut0 (
		.clk       (clk),
		.rst       (rst),
		.apb_req   (apb_req),
		.apb_resp  (apb_resp),
		.out_valid (out_valid),
		.out_desc  (out_desc),
		.out_ready (out_ready)
	);

	always #2 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_state = lfsr_next(stim_state);
			v = {v[30:0], stim_state[0]};
		end
		return v;
	endfunction

	// Burst at idx with left beats to go, as {last, len}
	function automatic logic [6:0] seg_burst(input stream_pkg::beat_idx_t idx, input int left);
		int room;
		room = 63 - int'(idx[5:0]);
		if (left <= room) begin
			return {1'b1, 6'(left)};
		end
		return {1'b0, 6'(room)};
	endfunction

	function automatic logic admits(input logic [CRED_W-1:0] cred,
		input stream_pkg::burst_len_t len);
		return cred > CRED_W'(len);
	endfunction

	function automatic int outstanding(input stream_pkg::desc_kind_e kind,
		input stream_pkg::app_t app);
		int n;
		n = 0;
		foreach (exp_q[i]) begin
			if (exp_q[i].kind == kind && exp_q[i].app == app) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic apb_access(input logic write, input stream_pkg::app_t app,
		input stream_pkg::reg_sel_e sel, input logic [31:0] data,
		output logic [31:0] rd, output logic slverr);
		@(posedge clk);
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= write;
		apb_req.paddr <= {6'd0, app, sel, 2'b00};
		apb_req.pwdata <= data;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		check_value("pready", 32'(apb_resp.pready), 32'd1);
		rd = apb_resp.prdata;
		slverr = apb_resp.pslverr;
		@(posedge clk);
		apb_req.psel <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic post_send(input stream_pkg::app_t app, input stream_pkg::req_len_t len);
		stream_pkg::out_desc_t d;
		logic [6:0]            b;
		int                    done;
		apb_access(1'b1, app, stream_pkg::REG_SEND_REQ, 32'(len), rdata, err);
		check_value("pslverr", 32'(err), 32'd0);
		done = 0;
		while (!err && done <= int'(len)) begin
			b = seg_burst(model_idx[app], int'(len) - done);
			d.kind = stream_pkg::DESC_SEND;
			d.app = app;
			d.idx = model_idx[app];
			d.len = b[5:0];
			d.last = b[6];
			exp_q.push_back(d);
			model_idx[app] = model_idx[app] + 15'(b[5:0]) + 15'd1;
			done += int'(b[5:0]) + 1;
			beat_total += int'(b[5:0]) + 1;
		end
		if (!err) begin
			model_done[app]++;
		end
	endtask

	task automatic grant_recv(input stream_pkg::app_t app, input stream_pkg::burst_len_t len);
		stream_pkg::out_desc_t d;
		d = '0;
		d.kind = stream_pkg::DESC_RECV;
		d.app = app;
		d.len = len;
		exp_q.push_back(d);
		model_cred[app] = model_cred[app] - CRED_W'(len) - CRED_W'(1);
		beat_total += int'(len) + 1;
	endtask

	task automatic post_recv(input stream_pkg::app_t app, input stream_pkg::burst_len_t len);
		apb_access(1'b1, app, stream_pkg::REG_RECV_REQ, 32'(len), rdata, err);
		check_value("pslverr", 32'(err), 32'd0);
		if (admits(model_cred[app], len)) begin
			grant_recv(app, len);
		end else begin
			held[app] = 1'b1;
			held_len[app] = len;
		end
	endtask

	task automatic add_credit(input stream_pkg::app_t app, input logic [CRED_W-1:0] amount);
		apb_access(1'b1, app, stream_pkg::REG_RECV_CRED, 32'(amount), rdata, err);
		check_value("pslverr", 32'(err), 32'd0);
		model_cred[app] = model_cred[app] + amount;
		if (held[app] && admits(model_cred[app], held_len[app])) begin
			grant_recv(app, held_len[app]);
			held[app] = 1'b0;
		end
	endtask

	task automatic read_expect(input stream_pkg::app_t app, input stream_pkg::reg_sel_e sel,
		input logic [31:0] exp);
		apb_access(1'b0, app, sel, 32'd0, rdata, err);
		check_value("prdata", rdata, exp);
	endtask

	task automatic wait_drained(input stream_pkg::desc_kind_e kind, input stream_pkg::app_t app);
		while (outstanding(kind, app) != 0) begin
			@(negedge clk);
		end
	endtask

	// Both valid and ready at the negedge means a transfer at the next edge
	always @(negedge clk) begin : compare_out
		int hit;
		hit = -1;
		if (!rst && out_valid && out_ready) begin
			foreach (exp_q[i]) begin
				if (hit < 0 && exp_q[i].kind == out_desc.kind && exp_q[i].app == out_desc.app) begin
					hit = i;
				end
			end
			if (hit < 0) begin
				errors++;
				$display("Unexpected descriptor of kind %0d for application %0d",
					out_desc.kind, out_desc.app);
			end else begin
				check_value("out_desc.idx", 32'(out_desc.idx), 32'(exp_q[hit].idx));
				check_value("out_desc.len", 32'(out_desc.len), 32'(exp_q[hit].len));
				check_value("out_desc.last", 32'(out_desc.last), 32'(exp_q[hit].last));
				exp_q.delete(hit);
			end
		end
	end

	always @(posedge clk) begin
		if (ready_random) begin
			ready_state = lfsr_next(ready_state);
			out_ready <= ready_state[0];
		end else begin
			out_ready <= 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > 20 * beat_total + 2000) begin
			$display("Timeout after %0d cycles, %0d descriptors still expected",
				cycles, exp_q.size());
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		apb_req = '0;
		out_ready = 1'b1;
		ready_random = 1'b0;
		stim_state = 32'h5a1b_3865;
		ready_state = 32'h5a1b_3865;
		errors = 0;
		checks = 0;
		beat_total = 0;
		cycles = 0;
		for (int a = 0; a < stream_pkg::N_APPS; a++) begin
			model_idx[a] = '0;
			model_cred[a] = '0;
			model_done[a] = 0;
			held[a] = 1'b0;
			held_len[a] = '0;
		end
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("out_valid", 32'(out_valid), 32'd0);
		check_value("pslverr", 32'(apb_resp.pslverr), 32'd0);

		// Random sends on all paths, then a second request each to carry idx over
		for (int a = 0; a < stream_pkg::N_APPS; a++) begin
			post_send(stream_pkg::app_t'(a), 15'(rand_bits(12)));
		end
		for (int a = 0; a < stream_pkg::N_APPS; a++) begin
			wait_drained(stream_pkg::DESC_SEND, stream_pkg::app_t'(a));
			post_send(stream_pkg::app_t'(a), 15'(rand_bits(12)));
		end
		for (int a = 0; a < stream_pkg::N_APPS; a++) begin
			wait_drained(stream_pkg::DESC_SEND, stream_pkg::app_t'(a));
			read_expect(stream_pkg::app_t'(a), stream_pkg::REG_SEND_DONE, 32'(model_done[a]));
			read_expect(stream_pkg::app_t'(a), stream_pkg::REG_SEND_DONE, 32'd0);
			model_done[a] = 0;
		end

		// Busy paths refuse a second request
		post_send(2'd0, 15'd3000);
		apb_access(1'b1, 2'd0, stream_pkg::REG_SEND_REQ, 32'd5, rdata, err);
		check_value("pslverr", 32'(err), 32'd1);
		add_credit(2'd1, 16'd10);
		post_recv(2'd1, 6'd40);
		apb_access(1'b1, 2'd1, stream_pkg::REG_RECV_REQ, 32'd3, rdata, err);
		check_value("pslverr", 32'(err), 32'd1);
		post_send(2'd2, 15'(rand_bits(11)));
		post_send(2'd3, 15'(rand_bits(11)));
		for (int a = 0; a < stream_pkg::N_APPS; a++) begin
			wait_drained(stream_pkg::DESC_SEND, stream_pkg::app_t'(a));
		end
		repeat (50) @(negedge clk);
		add_credit(2'd1, 16'd40);
		wait_drained(stream_pkg::DESC_RECV, 2'd1);
		read_expect(2'd1, stream_pkg::REG_RECV_CRED, 32'(model_cred[1]));

		// Mixed traffic under random back-pressure
		ready_random = 1'b1;
		for (int r = 0; r < 8; r++) begin
			for (int a = 0; a < stream_pkg::N_APPS; a++) begin
				wait_drained(stream_pkg::DESC_SEND, stream_pkg::app_t'(a));
				post_send(stream_pkg::app_t'(a), 15'(rand_bits(9)));
				wait_drained(stream_pkg::DESC_RECV, stream_pkg::app_t'(a));
				add_credit(stream_pkg::app_t'(a), 16'd64);
				post_recv(stream_pkg::app_t'(a), 6'(rand_bits(6)));
			end
		end
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		ready_random = 1'b0;
		repeat (20) @(negedge clk);
		check_value("out_valid", 32'(out_valid), 32'd0);
		for (int a = 0; a < stream_pkg::N_APPS; a++) begin
			read_expect(stream_pkg::app_t'(a), stream_pkg::REG_RECV_CRED, 32'(model_cred[a]));
			read_expect(stream_pkg::app_t'(a), stream_pkg::REG_SEND_DONE, 32'(model_done[a]));
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: host_stream_top.f
hw/stream_pkg.sv
hw/rr_arbiter.sv
hw/apb_regs.sv
hw/send_segmenter.sv
hw/recv_gate.sv
hw/desc_merger.sv
hw/host_stream_top.sv
verif/tb_host_stream.sv
